//--- Bender.yml
package:
  name: soc_bus

sources:
  - hdl/soc_pkg.sv
  - hdl/bus_splitter.sv
  - hdl/ram_arbiter.sv
  - hdl/boot_rom.sv
  - hdl/uart_tx.sv
  - hdl/soc_toplevel.sv
  - target: test
    files:
      - verification/soc_properties.sv
      - verification/soc_checker.sv
      - verification/soc_tb.sv

//--- hdl/boot_rom.sv
`default_nettype none
`timescale 1ns/100ps

module boot_rom (
    input  wire logic              clk,
    input  wire logic              reset_i,
    input  wire soc_pkg::bus_req_t req_i,
    output soc_pkg::bus_rsp_t      rsp_o
);

    logic [31:0] rom [soc_pkg::ROM_WORDS];
    logic        active;
    logic        pend_q;    // wait cycle done
    logic [31:0] rdata_q;

    initial begin
        for (int i = 0; i < soc_pkg::ROM_WORDS; i++) begin
            rom[i] = soc_pkg::rom_word(i);
        end
    end

    assign active = req_i.read | req_i.write;   // writes are ignored

    always_ff @(posedge clk) begin
        if (reset_i) begin
            pend_q <= 1'b0;
        end else begin
            pend_q <= active & ~pend_q;
        end
    end

    always_ff @(posedge clk) begin
        if (active & ~pend_q) begin
            rdata_q <= rom[req_i.addr[soc_pkg::ROM_AW+1:2]];
        end
    end

    assign rsp_o = '{rdata: rdata_q, stall: active & ~pend_q};

endmodule

`default_nettype wire

//--- hdl/bus_splitter.sv
`default_nettype none
`timescale 1ns/100ps

module bus_splitter #(
    parameter logic [31:0] B_BASE = soc_pkg::ROM_BASE,
    parameter logic [31:0] B_MASK = soc_pkg::ROM_MASK
) (
    input  wire soc_pkg::bus_req_t req_i,
    output soc_pkg::bus_rsp_t      rsp_o,

    output soc_pkg::bus_req_t      a_req_o,
    input  wire soc_pkg::bus_rsp_t a_rsp_i,

    output soc_pkg::bus_req_t      b_req_o,
    input  wire soc_pkg::bus_rsp_t b_rsp_i
);

    logic sel_b;

    assign sel_b = (req_i.addr & B_MASK) == B_BASE;

    always_comb begin
        a_req_o = req_i;
        b_req_o = req_i;
        // only the selected side sees a strobe
        if (sel_b) begin
            a_req_o.read  = 1'b0;
            a_req_o.write = 1'b0;
        end else begin
            b_req_o.read  = 1'b0;
            b_req_o.write = 1'b0;
        end
    end

    // address is held while stalled, so the mux stays on the right target
    always_comb begin
        if (sel_b) begin
            rsp_o = b_rsp_i;
        end else begin
            rsp_o = a_rsp_i;
        end
    end

endmodule

`default_nettype wire

//--- hdl/ram_arbiter.sv
`default_nettype none
`timescale 1ns/100ps

module ram_arbiter (
    input  wire logic              clk,
    input  wire logic              reset_i,

    input  wire soc_pkg::bus_req_t p0_req_i,
    output soc_pkg::bus_rsp_t      p0_rsp_o,

    input  wire soc_pkg::bus_req_t p1_req_i,
    output soc_pkg::bus_rsp_t      p1_rsp_o
);

    logic [31:0] mem [soc_pkg::RAM_WORDS];

    logic [1:0]  pend;
    logic [1:0]  want;       // pending and not yet served
    logic [1:0]  served_q;   // access done, completes this cycle
    logic [1:0]  gnt;
    logic        prio_q;     // 1 when port 1 wins a tie

    soc_pkg::bus_req_t           sel_req;
    logic [soc_pkg::RAM_AW-1:0]  idx;
    logic [31:0]                 rdata_q;

    assign pend[0] = p0_req_i.read | p0_req_i.write;
    assign pend[1] = p1_req_i.read | p1_req_i.write;
    assign want    = pend & ~served_q;

    always_comb begin
        if (want == 2'b11) begin
            gnt = prio_q ? 2'b10 : 2'b01;
        end else begin
            gnt = want;
        end
    end

    assign sel_req = gnt[1] ? p1_req_i : p0_req_i;
    assign idx     = sel_req.addr[soc_pkg::RAM_AW+1:2];   // upper bits ignored

    always_ff @(posedge clk) begin
        if (reset_i) begin
            served_q <= 2'b00;
            prio_q   <= 1'b0;
        end else begin
            served_q <= gnt;
            // loser of a tie wins the next one
            if (want == 2'b11) begin
                prio_q <= gnt[0];
            end
        end
    end

    // single port, read before write
    always_ff @(posedge clk) begin
        if (gnt != 2'b00) begin
            rdata_q <= mem[idx];
            if (sel_req.write) begin
                for (int b = 0; b < 4; b++) begin
                    if (sel_req.be[b]) begin
                        mem[idx][8*b +: 8] <= sel_req.wdata[8*b +: 8];
                    end
                end
            end
        end
    end

    // rdata only matters at the owning port's completion
    assign p0_rsp_o = '{rdata: rdata_q, stall: want[0]};
    assign p1_rsp_o = '{rdata: rdata_q, stall: want[1]};

endmodule

`default_nettype wire

//--- hdl/soc_pkg.sv
`default_nettype none

package soc_pkg;

    // one master request, held by the master until stall is low
    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  be;     // active high
        logic        read;
        logic        write;
    } bus_req_t;

    typedef struct packed {
        logic [31:0] rdata;
        logic        stall;
    } bus_rsp_t;

    localparam logic [31:0] RAM_BASE  = 32'h8000_0000;
    localparam int          RAM_WORDS = 1024;
    localparam int          RAM_AW    = $clog2(RAM_WORDS);    // index from addr[11:2]

    localparam logic [31:0] ROM_BASE  = 32'hbfc0_0000;
    localparam logic [31:0] ROM_MASK  = 32'hfff0_0000;
    localparam int          ROM_WORDS = 256;
    localparam int          ROM_AW    = $clog2(ROM_WORDS);
    localparam logic [31:0] ROM_SEED  = 32'hc0de_0000;

    localparam logic [31:0] UART_BASE = 32'hbfd0_03f8;        // data, status at +4
    localparam logic [31:0] UART_MASK = 32'hffff_fff8;
    localparam int          UART_DIV  = 8;                    // clocks per bit
    localparam int          UART_DW   = $clog2(UART_DIV);

    // boot image content, one word per index
    function automatic logic [31:0] rom_word(input int unsigned idx);
        logic [31:0] prod;
        prod = idx * 32'h0101_0101;
        return prod ^ ROM_SEED;
    endfunction

endpackage

`default_nettype wire

//--- hdl/soc_toplevel.sv
`default_nettype none
`timescale 1ns/100ps

module soc_toplevel (
    input  wire logic              clk,
    input  wire logic              reset_i,

    input  wire soc_pkg::bus_req_t ibus_req_i,
    output soc_pkg::bus_rsp_t      ibus_rsp_o,

    input  wire soc_pkg::bus_req_t dbus_req_i,
    output soc_pkg::bus_rsp_t      dbus_rsp_o,

    output logic                   txd_o
);

    wire soc_pkg::bus_req_t ibus_ram_req;
    wire soc_pkg::bus_rsp_t ibus_ram_rsp;
    wire soc_pkg::bus_req_t rom_req;
    wire soc_pkg::bus_rsp_t rom_rsp;

    wire soc_pkg::bus_req_t dbus_ram_req;
    wire soc_pkg::bus_rsp_t dbus_ram_rsp;
    wire soc_pkg::bus_req_t uart_req;
    wire soc_pkg::bus_rsp_t uart_rsp;

    bus_splitter #(
        .B_BASE(soc_pkg::ROM_BASE),
        .B_MASK(soc_pkg::ROM_MASK)
    ) u_ibus_split (
        .req_i   (ibus_req_i),
        .rsp_o   (ibus_rsp_o),
        .a_req_o (ibus_ram_req),
        .a_rsp_i (ibus_ram_rsp),
        .b_req_o (rom_req),
        .b_rsp_i (rom_rsp)
    );

    bus_splitter #(
        .B_BASE(soc_pkg::UART_BASE),
        .B_MASK(soc_pkg::UART_MASK)
    ) u_dbus_split (
        .req_i   (dbus_req_i),
        .rsp_o   (dbus_rsp_o),
        .a_req_o (dbus_ram_req),
        .a_rsp_i (dbus_ram_rsp),
        .b_req_o (uart_req),
        .b_rsp_i (uart_rsp)
    );

    // ibus on port 0, dbus on port 1
    ram_arbiter u_ram_arbiter (
        .clk      (clk),
        .reset_i  (reset_i),
        .p0_req_i (ibus_ram_req),
        .p0_rsp_o (ibus_ram_rsp),
        .p1_req_i (dbus_ram_req),
        .p1_rsp_o (dbus_ram_rsp)
    );

    boot_rom u_boot_rom (
        .clk     (clk),
        .reset_i (reset_i),
        .req_i   (rom_req),
        .rsp_o   (rom_rsp)
    );

    uart_tx u_uart_tx (
        .clk     (clk),
        .reset_i (reset_i),
        .req_i   (uart_req),
        .rsp_o   (uart_rsp),
        .txd_o   (txd_o)
    );

endmodule

`default_nettype wire

//--- hdl/uart_tx.sv
`default_nettype none
`timescale 1ns/100ps

module uart_tx (
    input  wire logic              clk,
    input  wire logic              reset_i,
    input  wire soc_pkg::bus_req_t req_i,
    output soc_pkg::bus_rsp_t      rsp_o,
    output logic                   txd_o
);

    logic                        is_stat;
    logic                        wr_data;
    logic                        accept;
    logic                        busy_q;
    logic [9:0]                  shift_q;   // stop, data, start
    logic [3:0]                  bit_q;
    logic [soc_pkg::UART_DW-1:0] div_q;
    logic                        bit_end;

    assign is_stat = req_i.addr[2];          // data at +0, status at +4
    assign wr_data = req_i.write & ~is_stat;
    assign accept  = wr_data & ~busy_q;
    assign bit_end = div_q == soc_pkg::UART_DW'(soc_pkg::UART_DIV - 1);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            busy_q  <= 1'b0;
            shift_q <= '1;                   // line idles high
            bit_q   <= '0;
            div_q   <= '0;
        end else if (accept) begin
            busy_q  <= 1'b1;
            shift_q <= {1'b1, req_i.wdata[7:0], 1'b0};
            bit_q   <= '0;
            div_q   <= '0;
        end else if (busy_q) begin
            if (bit_end) begin
                div_q   <= '0;
                shift_q <= {1'b1, shift_q[9:1]};
                bit_q   <= bit_q + 4'd1;
                // end of stop bit
                if (bit_q == 4'd9) begin
                    busy_q <= 1'b0;
                end
            end else begin
                div_q <= div_q + 1'b1;
            end
        end
    end

    assign txd_o = shift_q[0];

    // data reads give zero, status bit 0 is busy
    always_comb begin
        rsp_o.rdata = {31'b0, busy_q & is_stat & req_i.read};
        rsp_o.stall = wr_data & busy_q;      // hold writes until idle
    end

endmodule

`default_nettype wire

//--- soc_bus.f
hdl/soc_pkg.sv
hdl/bus_splitter.sv
hdl/ram_arbiter.sv
hdl/boot_rom.sv
hdl/uart_tx.sv
hdl/soc_toplevel.sv
verification/soc_properties.sv
verification/soc_checker.sv
verification/soc_tb.sv

//--- verification/soc_checker.sv
`default_nettype none
`timescale 1ns/100ps

module soc_checker (
    input  wire logic              clk,
    input  wire logic              reset_i,
    input  wire soc_pkg::bus_req_t ibus_req_i,
    input  wire soc_pkg::bus_rsp_t ibus_rsp_i,
    input  wire soc_pkg::bus_req_t dbus_req_i,
    input  wire soc_pkg::bus_rsp_t dbus_rsp_i,
    input  wire logic              txd_i,
    input  wire logic [2:0]        test_id_i,
    input  wire logic              test_end_i,
    output int                     ibus_done_o,
    output int                     dbus_done_o,
    output int                     err_total_o,
    output int                     tests_bad_o,
    output logic                   uart_quiet_o
);

    logic [31:0] ram_model [soc_pkg::RAM_WORDS];
    logic [3:0]  ram_known [soc_pkg::RAM_WORDS];   // bytes written so far
    logic [7:0]  uart_q [$];                       // accepted, not yet seen on txd
    logic [1:0]  stalled;
    logic        exp_busy;
    int          skip_cnt;                         // frame boundary, busy not checked
    logic        rx_on;
    int          rx_cnt;
    logic [7:0]  rx_byte;
    int          test_err;
    int          test_reqs;

    initial begin
        ibus_done_o  = 0;
        dbus_done_o  = 0;
        err_total_o  = 0;
        tests_bad_o  = 0;
        uart_quiet_o = 1'b1;
        stalled      = '0;
        exp_busy     = 1'b0;
        skip_cnt     = 0;
        rx_on        = 1'b0;
        rx_cnt       = 0;
        test_err     = 0;
        test_reqs    = 0;
        for (int i = 0; i < soc_pkg::RAM_WORDS; i++) begin
            ram_known[i] = 4'b0;
        end
    end

    function automatic string test_name(input logic [2:0] id);
        case (id)
            3'd0:    return "ram_rw";
            3'd1:    return "ram_shared";
            3'd2:    return "rom_fetch";
            3'd3:    return "uart_send";
            default: return "uart_status";
        endcase
    endfunction

    task automatic report_mismatch(input logic [31:0] exp, input logic [31:0] act);
        $display("mismatch %s expected %08h actual %08h", test_name(test_id_i), exp, act);
        test_err++;
    endtask

    task automatic report_fault(input string msg);
        $display("error in %s: %s", test_name(test_id_i), msg);
        test_err++;
    endtask

    task automatic check_done(input int p, input soc_pkg::bus_req_t r,
                              input soc_pkg::bus_rsp_t s);
        logic [9:0]  idx;
        logic [31:0] exp;
        logic [31:0] mask;
        logic        to_rom;
        logic        to_uart;
        idx     = r.addr[11:2];
        to_rom  = p == 0 && (r.addr & soc_pkg::ROM_MASK) == soc_pkg::ROM_BASE;
        to_uart = p == 1 && (r.addr & soc_pkg::UART_MASK) == soc_pkg::UART_BASE;
        if (!to_uart && !stalled[p]) begin
            report_fault($sformatf("access to %08h completed with no wait cycle", r.addr));
        end
        if (to_rom) begin
            exp = ({24'b0, r.addr[9:2]} * 32'h0101_0101) ^ soc_pkg::ROM_SEED;
            if (r.read && s.rdata !== exp) report_mismatch(exp, s.rdata);
        end else if (to_uart && r.addr[2]) begin
            if (stalled[p]) report_fault("status read was stalled");
            if (r.read && skip_cnt == 0 && s.rdata !== {31'b0, exp_busy}) begin
                report_mismatch({31'b0, exp_busy}, s.rdata);
            end
        end else if (to_uart) begin
            if (r.write && exp_busy) report_fault("UART write accepted during a frame");
            if (r.write) begin
                uart_q.push_back(r.wdata[7:0]);
                exp_busy = 1'b1;
                skip_cnt = 0;
            end
        end else begin
            for (int b = 0; b < 4; b++) begin
                mask[8*b +: 8] = {8{ram_known[idx][b]}};
            end
            if (r.read && (s.rdata & mask) !== (ram_model[idx] & mask)) begin
                report_mismatch(ram_model[idx], s.rdata);
            end
            for (int b = 0; b < 4; b++) begin
                if (r.write && r.be[b]) begin
                    ram_model[idx][8*b +: 8] = r.wdata[8*b +: 8];
                    ram_known[idx][b]        = 1'b1;
                end
            end
        end
        stalled[p] = 1'b0;
        test_reqs++;
        if (p == 0) ibus_done_o++; else dbus_done_o++;
    endtask

    task automatic watch_port(input int p, input soc_pkg::bus_req_t r,
                              input soc_pkg::bus_rsp_t s);
        if (r.read || r.write) begin
            if (s.stall) stalled[p] = 1'b1;
            else check_done(p, r, s);
        end
    endtask

    // start bit at the first low sample, every bit sampled mid period
    task automatic decode_txd();
        int bitn;
        if (!rx_on) begin
            rx_on  = !txd_i;
            rx_cnt = 0;
        end else begin
            rx_cnt++;
            bitn = rx_cnt / soc_pkg::UART_DIV;
            if (rx_cnt % soc_pkg::UART_DIV == soc_pkg::UART_DIV / 2) begin
                if (bitn == 0 && txd_i) begin
                    report_fault("start bit on txd too short");
                    rx_on = 1'b0;
                end else if (bitn >= 1 && bitn <= 8) begin
                    rx_byte[bitn-1] = txd_i;
                end else if (bitn == 9) begin
                    if (!txd_i) report_fault("stop bit on txd is low");
                    if (uart_q.size() == 0) report_fault("frame on txd with no UART write");
                    else if (uart_q[0] !== rx_byte) report_mismatch(uart_q[0], rx_byte);
                    if (uart_q.size() > 0) void'(uart_q.pop_front());
                    rx_on    = 1'b0;
                    exp_busy = 1'b0;
                    skip_cnt = soc_pkg::UART_DIV;
                end
            end
        end
    endtask

    task automatic close_test();
        $display("%s: %0d requests, %0d errors", test_name(test_id_i), test_reqs, test_err);
        if (test_err > 0) tests_bad_o++;
        err_total_o += test_err;
        test_err  = 0;
        test_reqs = 0;
    endtask

    always @(posedge clk) begin
        if (!reset_i) begin
            watch_port(0, ibus_req_i, ibus_rsp_i);
            watch_port(1, dbus_req_i, dbus_rsp_i);
            if (skip_cnt > 0) skip_cnt--;
            decode_txd();
            if (test_end_i) close_test();
        end
        uart_quiet_o = !exp_busy && !rx_on;
    end

endmodule

`default_nettype wire

//--- verification/soc_properties.sv
`default_nettype none
`timescale 1ns/100ps

module soc_properties (
    input wire logic              clk,
    input wire logic              reset_i,
    input wire soc_pkg::bus_req_t p0_req_i,
    input wire soc_pkg::bus_rsp_t p0_rsp_i,
    input wire soc_pkg::bus_req_t p1_req_i,
    input wire soc_pkg::bus_rsp_t p1_rsp_i
);

    int         fail_cnt = 0;
    logic [1:0] pend;
    logic [1:0] done;

    assign pend = {p1_req_i.read | p1_req_i.write, p0_req_i.read | p0_req_i.write};
    assign done = pend & ~{p1_rsp_i.stall, p0_rsp_i.stall};

    stall_after_reset: assert property (@(posedge clk)
        reset_i |=> !p0_rsp_i.stall && !p1_rsp_i.stall)
        else begin
            $error("arbiter stalls in the cycle after reset");
            fail_cnt++;
        end

    one_completion: assert property (@(posedge clk) disable iff (reset_i)
        done != 2'b11)
        else begin
            $error("both RAM ports completed in one cycle");
            fail_cnt++;
        end

    stall_needs_req: assert property (@(posedge clk) disable iff (reset_i)
        (p0_rsp_i.stall |-> pend[0]) and (p1_rsp_i.stall |-> pend[1]))
        else begin
            $error("RAM port stalls with no request");
            fail_cnt++;
        end

endmodule

bind ram_arbiter soc_properties u_props (
    .clk      (clk),
    .reset_i  (reset_i),
    .p0_req_i (p0_req_i),
    .p0_rsp_i (p0_rsp_o),
    .p1_req_i (p1_req_i),
    .p1_rsp_i (p1_rsp_o)
);

`default_nettype wire

//--- verification/soc_tb.sv
`default_nettype none
`timescale 1ns/100ps

module soc_tb;

    localparam int          CLK_HALF     = 50;
    localparam int          RESET_CYCLES = 5;
    localparam int          NUM_TESTS    = 5;
    localparam int          NUM_REQ      = 200;
    localparam int          REQ_CYCLES   = 120;   // one UART frame plus slack
    localparam logic [31:0] SEED         = 32'h9f85_b55a;

    logic              clk;
    logic              reset_i;
    soc_pkg::bus_req_t ibus_req;
    soc_pkg::bus_rsp_t ibus_rsp;
    soc_pkg::bus_req_t dbus_req;
    soc_pkg::bus_rsp_t dbus_rsp;
    logic              txd;
    logic [2:0]        test_id;
    logic              test_end;
    int                ibus_done;
    int                dbus_done;
    int                err_total;
    int                tests_bad;
    logic              uart_quiet;
    logic [31:0]       lcg_state [2];   // one stream per master
    int                assert_fails;

    soc_toplevel u_dut (
        .clk        (clk),
        .reset_i    (reset_i),
        .ibus_req_i (ibus_req),
        .ibus_rsp_o (ibus_rsp),
        .dbus_req_i (dbus_req),
        .dbus_rsp_o (dbus_rsp),
        .txd_o      (txd)
    );

    soc_checker u_chk (
        .clk          (clk),
        .reset_i      (reset_i),
        .ibus_req_i   (ibus_req),
        .ibus_rsp_i   (ibus_rsp),
        .dbus_req_i   (dbus_req),
        .dbus_rsp_i   (dbus_rsp),
        .txd_i        (txd),
        .test_id_i    (test_id),
        .test_end_i   (test_end),
        .ibus_done_o  (ibus_done),
        .dbus_done_o  (dbus_done),
        .err_total_o  (err_total),
        .tests_bad_o  (tests_bad),
        .uart_quiet_o (uart_quiet)
    );

    initial clk = 1'b0;
    always #CLK_HALF clk = ~clk;

    function automatic logic [15:0] lcg_next(input int p);
        lcg_state[p] = lcg_state[p] * 32'd1664525 + 32'd1013904223;
        return lcg_state[p][31:16];   // upper half only
    endfunction

    function automatic soc_pkg::bus_req_t make_req(input int test, input int p);
        soc_pkg::bus_req_t r;
        logic [15:0]       a;
        logic [15:0]       b;
        a       = lcg_next(p);
        b       = lcg_next(p);
        r.wdata = {lcg_next(p), b};
        r.be    = a[15:12];
        case (test)
            0, 1: begin   // 16 words, random upper bits
                r.addr  = soc_pkg::RAM_BASE | {16'h0, a[11:8], 6'h0, a[3:0], 2'b00};
                r.read  = a[4];
                r.write = ~a[4];
            end
            2: begin
                r.addr  = soc_pkg::ROM_BASE | {12'h0, b[9:0], a[7:0], 2'b00};
                r.write = a[11:10] == 2'b00;
                r.read  = ~r.write;
            end
            3: begin
                r.addr  = soc_pkg::UART_BASE;
                r.read  = 1'b0;
                r.write = 1'b1;
            end
            default: begin   // status reads with a write now and then
                r.write = a[9:8] == 2'b00;
                r.read  = ~r.write;
                r.addr  = r.write ? soc_pkg::UART_BASE : soc_pkg::UART_BASE + 32'd4;
            end
        endcase
        return r;
    endfunction

    task automatic set_req(input int p, input soc_pkg::bus_req_t r);
        if (p == 0) begin
            ibus_req = r;
        end else begin
            dbus_req = r;
        end
    endtask

    function automatic int done_count(input int p);
        return (p == 0) ? ibus_done : dbus_done;
    endfunction

    task automatic run_master(input int test, input int p);
        int base;
        int idle;
        base = done_count(p);
        for (int n = 0; n < NUM_REQ; n++) begin
            set_req(p, make_req(test, p));
            do begin
                @(negedge clk);
            end while (done_count(p) != base + n + 1);
            idle = lcg_next(p) % 3;
            if (idle > 0) begin
                set_req(p, '0);
                repeat (idle) @(negedge clk);
            end
        end
        set_req(p, '0);
    endtask

    initial begin
        reset_i      = 1'b1;
        ibus_req     = '0;
        dbus_req     = '0;
        test_id      = '0;
        test_end     = 1'b0;
        lcg_state[0] = SEED;
        lcg_state[1] = SEED ^ 32'h5a5a_a5a5;
        repeat (RESET_CYCLES) @(negedge clk);
        reset_i = 1'b0;
        @(negedge clk);   // one quiet cycle after reset
        for (int t = 0; t < NUM_TESTS; t++) begin
            test_id = 3'(t);
            case (t)
                1: fork
                    run_master(t, 0);
                    run_master(t, 1);
                join
                2: run_master(t, 0);
                default: run_master(t, 1);
            endcase
            while (!uart_quiet) @(negedge clk);   // last frame still on txd
            test_end = 1'b1;
            @(negedge clk);
            test_end = 1'b0;
        end
        assert_fails = u_dut.u_ram_arbiter.u_props.fail_cnt;
        $display("%0d tests, %0d with errors, %0d check errors, %0d assertion failures",
                 NUM_TESTS, tests_bad, err_total, assert_fails);
        if (err_total == 0 && assert_fails == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        repeat (RESET_CYCLES + NUM_TESTS * NUM_REQ * REQ_CYCLES) @(posedge clk);
        $display("timeout: requests or UART frames did not finish in %0d cycles",
                 NUM_TESTS * NUM_REQ * REQ_CYCLES);
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire
